/* hdl/BitScanPkg.sv */
package BitScanPkg;

	// operand and result words
	localparam int dataWidth = 32;

	// count results, wide enough to hold dataWidth itself
	localparam int countWidth = 6;

	localparam int opWidth = 3; // opcode field

	// opcodes, trailing side first
	localparam logic [opWidth-1:0] opNeg = 3'd0; // two's-complement negation
	localparam logic [opWidth-1:0] opLowIsolate = 3'd1; // lowest set bit only
	localparam logic [opWidth-1:0] opLowMask = 3'd2; // lowest set bit and up
	localparam logic [opWidth-1:0] opTrailZeros = 3'd3; // zeros below lowest set bit

	// leading side, on the reversed word
	localparam logic [opWidth-1:0] opHighIsolate = 3'd4; // highest set bit only
	localparam logic [opWidth-1:0] opHighMask = 3'd5; // highest set bit and down
	localparam logic [opWidth-1:0] opLeadZeros = 3'd6; // zeros above highest set bit

	// code 7 is reserved, result is zero

	// input register plus result register
	localparam int pipeLatency = 2;

	// prefix tree choice
	// 0 serial chain, smallest and slowest
	// 1 brent-kung, about 2*log2(n) levels
	// 2 sklansky, log2(n) levels with high fanout
	localparam int prefixSpeed = 2;

endpackage

/* hdl/PrefixOr.sv */
`timescale 1ns/100ps

module PrefixOr #(
	parameter int width = 8, // scanned word width
	parameter int speed = 2  // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] PI, // bits to scan
	output logic [width-1:0] PO  // running or from bit 0 upward
);

	localparam int depth = $clog2(width); // tree levels for one sweep

	if (speed == 2) begin : sklansky
		// one row per level, row 0 is the input
		logic [depth:0][width-1:0] lvl;

		assign lvl[0] = PI;

		for (genvar l = 1; l <= depth; l++) begin : levels
			localparam int half = 2 ** (l - 1); // size of a block half at this level

			for (genvar i = 0; i < width; i++) begin : bits
				// top bit of the lower half in the block holding i
				localparam int src = (i / (2 * half)) * (2 * half) + half - 1;

				if ((i / half) % 2 == 1) begin : black
					// upper half picks up the whole lower half
					assign lvl[l][i] = lvl[l-1][i] | lvl[l-1][src];
				end else begin : white
					assign lvl[l][i] = lvl[l-1][i]; // lower half already done
				end
			end
		end

		assign PO = lvl[depth];
	end else if (speed == 1) begin : brentKung
		// rows 1..depth sweep up, rows depth+1..2*depth-1 sweep down
		logic [2*depth-1:0][width-1:0] lvl;

		assign lvl[0] = PI;

		for (genvar l = 1; l <= depth; l++) begin : upSweep
			localparam int span = 2 ** l;
			localparam int half = 2 ** (l - 1);

			for (genvar i = 0; i < width; i++) begin : bits
				if ((i + 1) % span == 0) begin : black
					assign lvl[l][i] = lvl[l-1][i] | lvl[l-1][i-half]; // merge two halves
				end else begin : white
					assign lvl[l][i] = lvl[l-1][i];
				end
			end
		end

		// after the up sweep every bit 2**k-1 holds its full prefix
		for (genvar l = depth + 1; l < 2 * depth; l++) begin : downSweep
			localparam int span = 2 ** (2 * depth - l); // shrinks by half per row
			localparam int half = span / 2;

			for (genvar i = 0; i < width; i++) begin : bits
				if (((i + 1) % span == half) && (i >= span)) begin : black
					// i-half ends a finished block, i covers the half above it
					assign lvl[l][i] = lvl[l-1][i] | lvl[l-1][i-half];
				end else begin : white
					assign lvl[l][i] = lvl[l-1][i];
				end
			end
		end

		assign PO = lvl[2*depth-1];
	end else begin : serial
		logic [width-1:0] chain; // ripple, depth grows with width

		assign chain[0] = PI[0];

		for (genvar i = 1; i < width; i++) begin : bits
			assign chain[i] = chain[i-1] | PI[i];
		end

		assign PO = chain;
	end

endmodule

/* hdl/ThermoCount.sv */
`timescale 1ns/100ps

module ThermoCount #(
	parameter int width = 32 // mask width
) (
	input  logic [width-1:0] mask,                     // low zeros, then ones
	output logic [BitScanPkg::countWidth-1:0] count    // number of low zeros
);

	import BitScanPkg::*;

	// one step per count bit, enough to reach width itself
	localparam int steps = $clog2(width + 1);

	// successive approximation on the boundary
	// mask[j] is zero exactly when j lies below the first one,
	// so each step tries to move the lower edge up by a power of two
	always_comb begin
		logic [countWidth-1:0] acc;
		int probe;

		acc = '0;
		for (int b = steps - 1; b >= 0; b--) begin
			probe = int'(acc) + (1 << b); // candidate count
			if (probe <= width) begin
				// still zero at probe-1, boundary lies above
				if (!mask[probe-1]) begin
					acc = acc + countWidth'(1 << b);
				end
			end
		end
		count = acc; // all-zero mask walks up to width
	end

endmodule

/* hdl/LowScan.sv */
`timescale 1ns/100ps

module LowScan (
	input  logic [BitScanPkg::dataWidth-1:0] data,     // operand
	output logic [BitScanPkg::dataWidth-1:0] neg,      // -data mod 2**dataWidth
	output logic [BitScanPkg::dataWidth-1:0] isolate,  // lowest set bit only
	output logic [BitScanPkg::dataWidth-1:0] mask,     // lowest set bit and up
	output logic [BitScanPkg::countWidth-1:0] count    // trailing zeros
);

	import BitScanPkg::*;

	logic [dataWidth-1:0] prefix; // or of bits 0..i
	logic [dataWidth-1:0] below;  // prefix one position lower

	// runs upward from bit 0, first one sets the rest
	PrefixOr #(
		.width(dataWidth),
		.speed(prefixSpeed)
	) prefixLow (
		.PI(data),
		.PO(prefix)
	);

	assign below = {prefix[dataWidth-2:0], 1'b0}; // bit 0 has nothing below

	assign mask = prefix;

	// only the first one of the mask survives
	assign isolate = prefix & ~below;

	// negation keeps bits up to the lowest one, flips those above
	// same as ~data + 1 without a carry chain
	assign neg = data ^ below;

	// zeros below the mask edge
	ThermoCount #(
		.width(dataWidth)
	) countLow (
		.mask(prefix),
		.count(count)
	);

endmodule

/* hdl/HighScan.sv */
`timescale 1ns/100ps

module HighScan (
	input  logic [BitScanPkg::dataWidth-1:0] data,     // operand
	output logic [BitScanPkg::dataWidth-1:0] isolate,  // highest set bit only
	output logic [BitScanPkg::dataWidth-1:0] mask,     // highest set bit and down
	output logic [BitScanPkg::countWidth-1:0] count    // leading zeros
);

	import BitScanPkg::*;

	logic [dataWidth-1:0] revData; // msb now at bit 0
	logic [dataWidth-1:0] revMask; // prefix on reversed word
	logic [dataWidth-1:0] above;   // mask one position higher

	// reversal is wiring only
	always_comb begin
		for (int i = 0; i < dataWidth; i++) begin
			revData[i] = data[dataWidth-1-i];
		end
	end

	// same upward scan as the low side, reversed input
	PrefixOr #(
		.width(dataWidth),
		.speed(prefixSpeed)
	) prefixHigh (
		.PI(revData),
		.PO(revMask)
	);

	// low zeros of reversed mask are the leading zeros
	ThermoCount #(
		.width(dataWidth)
	) countHigh (
		.mask(revMask),
		.count(count)
	);

	// back to normal bit order
	always_comb begin
		for (int i = 0; i < dataWidth; i++) begin
			mask[i] = revMask[dataWidth-1-i];
		end
	end

	assign above = {1'b0, mask[dataWidth-1:1]}; // top bit has nothing above

	assign isolate = mask & ~above; // top one of the mask
endmodule

/* hdl/ScanResult.sv */
`timescale 1ns/100ps

module ScanResult (
	input  logic clk,
	input  logic arstN,
	input  logic valid,                                    // stage strobe
	input  logic [BitScanPkg::opWidth-1:0] op,
	input  logic [BitScanPkg::dataWidth-1:0] data,         // staged operand
	input  logic [BitScanPkg::dataWidth-1:0] lowNeg,
	input  logic [BitScanPkg::dataWidth-1:0] lowIsolate,
	input  logic [BitScanPkg::dataWidth-1:0] lowMask,
	input  logic [BitScanPkg::countWidth-1:0] lowCount,
	input  logic [BitScanPkg::dataWidth-1:0] highIsolate,
	input  logic [BitScanPkg::dataWidth-1:0] highMask,
	input  logic [BitScanPkg::countWidth-1:0] highCount,
	output logic outValid,                                 // one pulse per input
	output logic [BitScanPkg::dataWidth-1:0] outData,
	output logic outZero                                   // operand was zero
);

	import BitScanPkg::*;

	localparam int padWidth = dataWidth - countWidth; // zero fill for counts

	logic [dataWidth-1:0] selData; // word for this opcode
	logic selZero;

	// isolated bits are taken from the word itself
	always_comb begin
		case (op)
			opNeg: selData = lowNeg;
			opLowIsolate: selData = lowIsolate & data;
			opLowMask: selData = lowMask;
			opTrailZeros: selData = {{padWidth{1'b0}}, lowCount};
			opHighIsolate: selData = highIsolate & data;
			opHighMask: selData = highMask;
			opLeadZeros: selData = {{padWidth{1'b0}}, highCount};
			default: selData = '0; // reserved code
		endcase
	end

	// top of the prefix or covers the whole word
	assign selZero = ~lowMask[dataWidth-1];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
			outData <= '0;
			outZero <= 1'b0;
		end else begin
			outValid <= valid; // no stall, strobe just follows
			if (valid) begin
				outData <= selData;
				outZero <= selZero;
			end
		end
	end

endmodule

/* hdl/BitScanTop.sv */
`timescale 1ns/100ps

module BitScanTop (
	input  logic clk,
	input  logic arstN,
	input  logic inValid,                                // take word this edge
	input  logic [BitScanPkg::opWidth-1:0] inOp,
	input  logic [BitScanPkg::dataWidth-1:0] inData,
	output logic outValid,                               // two edges after input
	output logic [BitScanPkg::dataWidth-1:0] outData,
	output logic outZero
);

	import BitScanPkg::*;

	// input register stage
	logic stValid;
	logic [opWidth-1:0] stOp;
	logic [dataWidth-1:0] stData;

	// scan results, valid in the stage cycle
	logic [dataWidth-1:0] lowNeg;
	logic [dataWidth-1:0] lowIsolate;
	logic [dataWidth-1:0] lowMask;
	logic [countWidth-1:0] lowCount;
	logic [dataWidth-1:0] highIsolate;
	logic [dataWidth-1:0] highMask;
	logic [countWidth-1:0] highCount;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			stValid <= 1'b0;
			stOp <= '0;
			stData <= '0;
		end else begin
			stValid <= inValid;
			if (inValid) begin // hold word between strobes
				stOp <= inOp;
				stData <= inData;
			end
		end
	end

	// both sides work on the same staged word
	LowScan lowPath (
		.data(stData),
		.neg(lowNeg),
		.isolate(lowIsolate),
		.mask(lowMask),
		.count(lowCount)
	);

	HighScan highPath (
		.data(stData),
		.isolate(highIsolate),
		.mask(highMask),
		.count(highCount)
	);

	// select and register, second pipeline stage
	ScanResult result (
		.clk(clk), .arstN(arstN),
		.valid(stValid), .op(stOp), .data(stData),
		.lowNeg(lowNeg), .lowIsolate(lowIsolate),
		.lowMask(lowMask), .lowCount(lowCount),
		.highIsolate(highIsolate), .highMask(highMask), .highCount(highCount),
		.outValid(outValid), .outData(outData), .outZero(outZero)
	);

endmodule

/* tests/BitScanModel.svh */
`ifndef BITSCANMODEL_SVH
`define BITSCANMODEL_SVH

// zeros below the lowest one, dataWidth for a zero word
function automatic int modelTrailZeros(input logic [dataWidth-1:0] word);
	int n;
	n = dataWidth;
	for (int i = dataWidth - 1; i >= 0; i--) begin
		if (word[i]) n = i; // last hit is the lowest one
	end
	return n;
endfunction

// zeros above the highest one
function automatic int modelLeadZeros(input logic [dataWidth-1:0] word);
	int n;
	n = dataWidth;
	for (int i = 0; i < dataWidth; i++) begin
		if (word[i]) n = dataWidth - 1 - i; // last hit is the highest one
	end
	return n;
endfunction

// expected word for one opcode
function automatic logic [dataWidth-1:0] modelResult(input logic [opWidth-1:0] op,
		input logic [dataWidth-1:0] word);
	logic [dataWidth-1:0] res;
	int tz;
	int top;
	tz = modelTrailZeros(word);
	top = dataWidth - 1 - modelLeadZeros(word); // -1 when word is zero
	res = '0;
	case (op)
		opNeg: res = ~word + 1'b1; // two's complement
		opLowIsolate: if (tz < dataWidth) res[tz] = 1'b1;
		opLowMask: for (int i = tz; i < dataWidth; i++) res[i] = 1'b1;
		opTrailZeros: res = dataWidth'(tz);
		opHighIsolate: if (top >= 0) res[top] = 1'b1;
		opHighMask: for (int i = 0; i <= top; i++) res[i] = 1'b1;
		opLeadZeros: res = dataWidth'(modelLeadZeros(word));
		default: res = '0; // reserved
	endcase
	return res;
endfunction

function automatic logic modelZero(input logic [dataWidth-1:0] word);
	return (word == '0);
endfunction

`endif

/* tests/BitScanTb.sv */
`timescale 1ns/100ps

module BitScanTb;

	import BitScanPkg::*;

	`include "BitScanModel.svh"

	localparam int resetCycles = 10;
	localparam int numRandom = 16;                     // random words per scan test
	localparam int numWords = dataWidth + numRandom;   // single bits, then random
	localparam int numStream = 40;
	// every driven input, test by test
	localparam int numInputs = 1 + 6 * numWords + (numRandom + 3) + 9 + numStream;
	localparam int drainCycles = 30;                   // idle gaps and last results
	localparam int cycleLimit = 2 * numInputs + resetCycles + drainCycles;

	logic clk;
	logic arstN;
	logic inValid;
	logic [opWidth-1:0] inOp;
	logic [dataWidth-1:0] inData;
	logic outValid;
	logic [dataWidth-1:0] outData;
	logic outZero;

	int valueErrors = 0;
	int strobeErrors = 0;
	int cycleCount = 0;

	logic [dataWidth-1:0] scanWords [numWords]; // shared by both scan tests

	BitScanTop UUT (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inOp(inOp),
		.inData(inData),
		.outValid(outValid),
		.outData(outData),
		.outZero(outZero)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout, run stopped after %0d cycles", cycleCount);
			$display("Test FAILED");
			$finish;
		end
	end

	// output word and zero flag against the model
	task automatic compareOut(input logic [opWidth-1:0] op, input logic [dataWidth-1:0] word);
		logic [dataWidth-1:0] expData;
		logic expZero;
		expData = modelResult(op, word);
		expZero = modelZero(word);
		assert (outData === expData) else begin
			$display("Fail outData op %h in %h: expected %h, actual %h",
				op, word, expData, outData);
			valueErrors++;
		end
		assert (outZero === expZero) else begin
			$display("Fail outZero op %h in %h: expected %h, actual %h",
				op, word, expZero, outZero);
			valueErrors++;
		end
	endtask

	// one word in, wait for its pulse, check; starts and ends just after a falling edge
	task automatic runOne(input logic [opWidth-1:0] op, input logic [dataWidth-1:0] word);
		int waited;
		inValid = 1'b1;
		inOp = op;
		inData = word;
		waited = 0;
		do begin
			@(negedge clk);
			inValid = 1'b0; // single strobe
			waited++;
		end while (!outValid && waited <= pipeLatency);
		assert (outValid) else begin
			$display("no outValid within %0d cycles for op %h, word %h", waited, op, word);
			strobeErrors++;
		end
		if (outValid) begin
			assert (waited == pipeLatency) else begin
				$display("result for op %h came %0d cycles after input instead of %0d",
					op, waited, pipeLatency);
				strobeErrors++;
			end
			compareOut(op, word);
		end
	endtask

	task automatic fillWords();
		for (int i = 0; i < dataWidth; i++) begin
			scanWords[i] = 1 << i; // single set bit
		end
		for (int k = 0; k < numRandom; k++) begin
			// clear a random run of low bits so counts spread out
			scanWords[dataWidth + k] = $urandom & ~((32'h1 << ($urandom % 32)) - 1);
		end
	endtask

	task automatic checkResetLatency();
		repeat (5) begin
			@(negedge clk);
			assert (outValid === 1'b0) else begin
				$display("outValid high after reset with no input");
				strobeErrors++;
			end
		end
		runOne(opTrailZeros, 32'h0000_0100);
		@(negedge clk);
		assert (outValid === 1'b0) else begin
			$display("outValid stayed high longer than one cycle");
			strobeErrors++;
		end
	endtask

	task automatic checkTrailing();
		foreach (scanWords[k]) begin
			runOne(opTrailZeros, scanWords[k]);
			runOne(opLowIsolate, scanWords[k]);
			runOne(opLowMask, scanWords[k]);
		end
	endtask

	task automatic checkLeading();
		foreach (scanWords[k]) begin
			runOne(opLeadZeros, scanWords[k]);
			runOne(opHighIsolate, scanWords[k]);
			runOne(opHighMask, scanWords[k]);
		end
	endtask

	task automatic checkNegation();
		runOne(opNeg, 32'h0000_0000);
		runOne(opNeg, 32'h0000_0001);
		runOne(opNeg, 32'h8000_0000); // maps to itself
		repeat (numRandom) runOne(opNeg, $urandom);
	endtask

	task automatic checkZeroWord();
		for (int op = 0; op < 8; op++) begin
			runOne(opWidth'(op), 32'h0000_0000); // 7 is the reserved code
		end
		runOne(3'd7, 32'hDEAD_BEEF); // reserved gives zero for any word
	endtask

	// one input per cycle, results checked in order as they come out
	task automatic checkStreaming();
		logic [dataWidth-1:0] words [numStream];
		logic [opWidth-1:0] ops [numStream];
		for (int j = 0; j < numStream; j++) begin
			ops[j] = opWidth'($urandom % 8);
			words[j] = (j % 10 == 3) ? '0 : $urandom; // a few zero words mixed in
		end
		inValid = 1'b0;
		@(negedge clk); // let the last single result leave
		for (int j = 0; j < numStream + pipeLatency; j++) begin
			if (j >= pipeLatency) begin
				assert (outValid === 1'b1) else begin
					$display("missing outValid for stream item %0d", j - pipeLatency);
					strobeErrors++;
				end
				compareOut(ops[j-pipeLatency], words[j-pipeLatency]);
			end else begin
				assert (outValid === 1'b0) else begin
					$display("outValid before the first stream result");
					strobeErrors++;
				end
			end
			inValid = (j < numStream);
			if (j < numStream) begin
				inOp = ops[j];
				inData = words[j];
			end
			@(negedge clk);
		end
		assert (outValid === 1'b0) else begin
			$display("extra outValid after the stream ended");
			strobeErrors++;
		end
	endtask

	initial begin
		arstN = 1'b0;
		inValid = 1'b0;
		inOp = '0;
		inData = '0;
		void'($urandom(49506)); // seed once
		fillWords();
		repeat (resetCycles) @(negedge clk);
		arstN = 1'b1;

		checkResetLatency();
		checkTrailing();
		checkLeading();
		checkNegation();
		checkZeroWord();
		checkStreaming();

		$display("value errors %0d, strobe errors %0d", valueErrors, strobeErrors);
		if (valueErrors == 0 && strobeErrors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+tests
hdl/BitScanPkg.sv
hdl/PrefixOr.sv
hdl/ThermoCount.sv
hdl/LowScan.sv
hdl/HighScan.sv
hdl/ScanResult.sv
hdl/BitScanTop.sv
tests/BitScanTb.sv
